/* vmul_pkg.sv */
/*
 * Vector multiply package.
 * Shared widths, instruction field positions and the opcode and
 * element size encodings of the vector multiply unit.
 */
package vmul_pkg;

    // Datapath geometry.
    localparam int vlen        = 128;
    localparam int vd_width    = 5;
    localparam int instr_width = 16;

    // Instruction word layout. Bits above the vd field are ignored.
    localparam int funct_lsb   = 0;
    localparam int funct_width = 4;
    localparam int sew_lsb     = 4;
    localparam int sew_width   = 2;
    localparam int vd_lsb      = 6;

    // Register depth of every scalar multiplier array.
    localparam int mul_stages = 2;

    typedef logic [vlen-1:0]        vreg_data_t;
    typedef logic [vd_width-1:0]    vreg_addr_t;
    typedef logic [instr_width-1:0] instr_t;

    // Supported operations, any other funct value is illegal.
    typedef enum logic [funct_width-1:0] {
        OP_VMUL   = 4'd0,   // Low half of each product.
        OP_VMULHU = 4'd1,   // High half of each product.
        OP_VWMULU = 4'd2    // Full double-width products.
    } vmul_op_e;

    // Element width of each lane.
    typedef enum logic [sew_width-1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

endpackage : vmul_pkg

/* vmul_decode.sv */
/*
 * Vector multiply decode stage.
 * Splits the instruction word into operation, element size and
 * destination, flags unknown functs and registers them with the operands.
 */
module vmul_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  logic                 in_valid,
    input  vmul_pkg::instr_t     in_instr,
    input  vmul_pkg::vreg_data_t in_srca,
    input  vmul_pkg::vreg_data_t in_srcb,
    output logic                 dec_valid,
    output vmul_pkg::vmul_op_e   dec_op,
    output vmul_pkg::sew_e       dec_sew,
    output vmul_pkg::vreg_addr_t dec_vd,
    output logic                 dec_illegal,
    output vmul_pkg::vreg_data_t dec_srca,
    output vmul_pkg::vreg_data_t dec_srcb
);

    import vmul_pkg::*;

    logic [funct_width-1:0] funct;
    logic                   illegal;

    assign funct = in_instr[funct_lsb +: funct_width];

    always_comb begin
        case (funct)
            OP_VMUL, OP_VMULHU, OP_VWMULU: illegal = 1'b0;
            default:                       illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (advance) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            dec_op      <= vmul_op_e'(funct);   // Raw value is kept, illegal travels beside it.
            dec_sew     <= sew_e'(in_instr[sew_lsb +: sew_width]);
            dec_vd      <= in_instr[vd_lsb +: vd_width];
            dec_illegal <= illegal;
            dec_srca    <= in_srca;
            dec_srcb    <= in_srcb;
        end
    end

    // The valid bit must come out of reset clean and stay that way.
    a_dec_valid_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(dec_valid)
    ) else $error("dec_valid is unknown after reset.");

endmodule : vmul_decode

/* mul_array.sv */
/*
 * Pipelined unsigned scalar multiplier.
 * Behavioral product followed by two register stages that synthesis
 * may retime, both held by the common pipeline enable.
 */
module mul_array #(
    parameter int WIDTH = 8
) (
    input  logic                 clk,
    input  logic                 advance,
    input  logic [WIDTH-1:0]     srca,
    input  logic [WIDTH-1:0]     srcb,
    output logic [2*WIDTH-1:0]   result
);

    logic [2*WIDTH-1:0] product;
    logic [2*WIDTH-1:0] prod_q1;
    logic [2*WIDTH-1:0] prod_q2;

    // Both operands are unsigned, so the plain product is exact.
    assign product = srca * srcb;

    always_ff @(posedge clk) begin
        if (advance) begin
            prod_q1 <= product;
            prod_q2 <= prod_q1;     // Second stage gives retiming room.
        end
    end

    assign result = prod_q2;

endmodule : mul_array

/* vmul_execute.sv */
/*
 * Vector multiply execute stage.
 * One array of scalar multipliers per element width, a control pipeline
 * that follows the products, and selection of the product set by width.
 */
module vmul_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  logic                 dec_valid,
    input  vmul_pkg::vmul_op_e   dec_op,
    input  vmul_pkg::sew_e       dec_sew,
    input  vmul_pkg::vreg_addr_t dec_vd,
    input  logic                 dec_illegal,
    input  vmul_pkg::vreg_data_t dec_srca,
    input  vmul_pkg::vreg_data_t dec_srcb,
    output logic                 ex_valid,
    output vmul_pkg::vmul_op_e   ex_op,
    output vmul_pkg::sew_e       ex_sew,
    output vmul_pkg::vreg_addr_t ex_vd,
    output logic                 ex_illegal,
    output vmul_pkg::vreg_data_t ex_prod_lo,
    output vmul_pkg::vreg_data_t ex_prod_hi
);

    import vmul_pkg::*;

    logic [2*vlen-1:0] mul8_result;
    logic [2*vlen-1:0] mul16_result;
    logic [2*vlen-1:0] mul32_result;
    logic [2*vlen-1:0] mul64_result;

    logic [mul_stages-1:0] valid_pipe;
    vmul_op_e              op_pipe      [mul_stages];
    sew_e                  sew_pipe     [mul_stages];
    vreg_addr_t            vd_pipe      [mul_stages];
    logic                  illegal_pipe [mul_stages];

    for (genvar idx = 0; idx < vlen / 8; idx++) begin : gen_mul8
        mul_array #(.WIDTH(8)) u_mul (
            .clk     (clk),
            .advance (advance),
            .srca    (dec_srca[idx*8 +: 8]),
            .srcb    (dec_srcb[idx*8 +: 8]),
            .result  (mul8_result[idx*16 +: 16])
        );
    end

    for (genvar idx = 0; idx < vlen / 16; idx++) begin : gen_mul16
        mul_array #(.WIDTH(16)) u_mul (
            .clk     (clk),
            .advance (advance),
            .srca    (dec_srca[idx*16 +: 16]),
            .srcb    (dec_srcb[idx*16 +: 16]),
            .result  (mul16_result[idx*32 +: 32])
        );
    end

    for (genvar idx = 0; idx < vlen / 32; idx++) begin : gen_mul32
        mul_array #(.WIDTH(32)) u_mul (
            .clk     (clk),
            .advance (advance),
            .srca    (dec_srca[idx*32 +: 32]),
            .srcb    (dec_srcb[idx*32 +: 32]),
            .result  (mul32_result[idx*64 +: 64])
        );
    end

    for (genvar idx = 0; idx < vlen / 64; idx++) begin : gen_mul64
        mul_array #(.WIDTH(64)) u_mul (
            .clk     (clk),
            .advance (advance),
            .srca    (dec_srca[idx*64 +: 64]),
            .srcb    (dec_srcb[idx*64 +: 64]),
            .result  (mul64_result[idx*128 +: 128])
        );
    end

    // Tags walk beside the multipliers so each one leaves with its product.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else if (advance) begin
            valid_pipe <= {valid_pipe[mul_stages-2:0], dec_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            op_pipe[0]      <= dec_op;
            sew_pipe[0]     <= dec_sew;
            vd_pipe[0]      <= dec_vd;
            illegal_pipe[0] <= dec_illegal;
            for (int s = 1; s < mul_stages; s++) begin
                op_pipe[s]      <= op_pipe[s-1];
                sew_pipe[s]     <= sew_pipe[s-1];
                vd_pipe[s]      <= vd_pipe[s-1];
                illegal_pipe[s] <= illegal_pipe[s-1];
            end
        end
    end

    assign ex_valid   = valid_pipe[mul_stages-1];
    assign ex_op      = op_pipe[mul_stages-1];
    assign ex_sew     = sew_pipe[mul_stages-1];
    assign ex_vd      = vd_pipe[mul_stages-1];
    assign ex_illegal = illegal_pipe[mul_stages-1];

    always_comb begin
        case (ex_sew)
            SEW_8:   {ex_prod_hi, ex_prod_lo} = mul8_result;
            SEW_16:  {ex_prod_hi, ex_prod_lo} = mul16_result;
            SEW_32:  {ex_prod_hi, ex_prod_lo} = mul32_result;
            default: {ex_prod_hi, ex_prod_lo} = mul64_result;
        endcase
    end

    // The delayed size must match a valid item leaving the multipliers.
    a_ex_sew_known: assert property (
        @(posedge clk) disable iff (reset) ex_valid |-> !$isunknown(ex_sew)
    ) else $error("ex_sew is unknown while ex_valid is high.");

endmodule : vmul_execute

/* vmul_result.sv */
/*
 * Vector multiply result stage.
 * Picks the low or high half of every lane product or passes the full
 * products through, and holds the output register under back-pressure.
 */
module vmul_result (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  logic                 ex_valid,
    input  vmul_pkg::vmul_op_e   ex_op,
    input  vmul_pkg::sew_e       ex_sew,
    input  vmul_pkg::vreg_addr_t ex_vd,
    input  logic                 ex_illegal,
    input  vmul_pkg::vreg_data_t ex_prod_lo,
    input  vmul_pkg::vreg_data_t ex_prod_hi,
    output logic                 out_valid,
    output vmul_pkg::vreg_data_t out_data_lo,
    output vmul_pkg::vreg_data_t out_data_hi,
    output logic                 out_wide,
    output vmul_pkg::vreg_addr_t out_vd,
    output logic                 out_illegal
);

    import vmul_pkg::*;

    vreg_data_t data_lo_next;
    vreg_data_t data_hi_next;
    logic       wide_next;

    // Lane i of the product set sits at bits 2*i*w, its half is w wide.
    function automatic vreg_data_t pick_half(logic [2*vlen-1:0] prod, sew_e sew, logic high);
        vreg_data_t res;
        res = '0;
        case (sew)
            SEW_8:
                for (int i = 0; i < vlen / 8; i++)
                    res[i*8 +: 8] = prod[i*16 + (high ? 8 : 0) +: 8];
            SEW_16:
                for (int i = 0; i < vlen / 16; i++)
                    res[i*16 +: 16] = prod[i*32 + (high ? 16 : 0) +: 16];
            SEW_32:
                for (int i = 0; i < vlen / 32; i++)
                    res[i*32 +: 32] = prod[i*64 + (high ? 32 : 0) +: 32];
            default:
                for (int i = 0; i < vlen / 64; i++)
                    res[i*64 +: 64] = prod[i*128 + (high ? 64 : 0) +: 64];
        endcase
        return res;
    endfunction

    always_comb begin
        data_lo_next = '0;
        data_hi_next = '0;
        wide_next    = 1'b0;
        if (!ex_illegal) begin
            case (ex_op)
                OP_VMUL:   data_lo_next = pick_half({ex_prod_hi, ex_prod_lo}, ex_sew, 1'b0);
                OP_VMULHU: data_lo_next = pick_half({ex_prod_hi, ex_prod_lo}, ex_sew, 1'b1);
                OP_VWMULU: begin
                    data_lo_next = ex_prod_lo;  // First half of the lanes.
                    data_hi_next = ex_prod_hi;
                    wide_next    = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_data_lo <= data_lo_next;
            out_data_hi <= data_hi_next;
            out_wide    <= wide_next;
            out_vd      <= ex_vd;
            out_illegal <= ex_illegal;
        end
    end

endmodule : vmul_result

/* vmul_unit.sv */
/*
 * Pipelined vector integer multiply unit.
 * Decode, multiply and result stages that stall together whenever a
 * valid output is not accepted.
 */
module vmul_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  vmul_pkg::instr_t     in_instr,
    input  vmul_pkg::vreg_data_t in_srca,
    input  vmul_pkg::vreg_data_t in_srcb,
    output logic                 in_ready,
    output logic                 out_valid,
    output vmul_pkg::vreg_data_t out_data_lo,
    output vmul_pkg::vreg_data_t out_data_hi,
    output logic                 out_wide,
    output vmul_pkg::vreg_addr_t out_vd,
    output logic                 out_illegal,
    input  logic                 out_ready
);

    import vmul_pkg::*;

    logic       advance;
    logic       dec_valid;
    vmul_op_e   dec_op;
    sew_e       dec_sew;
    vreg_addr_t dec_vd;
    logic       dec_illegal;
    vreg_data_t dec_srca;
    vreg_data_t dec_srcb;
    logic       ex_valid;
    vmul_op_e   ex_op;
    sew_e       ex_sew;
    vreg_addr_t ex_vd;
    logic       ex_illegal;
    vreg_data_t ex_prod_lo;
    vreg_data_t ex_prod_hi;

    // The whole pipeline moves unless a valid output waits for its consumer.
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    vmul_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_srca     (in_srca),
        .in_srcb     (in_srcb),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_sew     (dec_sew),
        .dec_vd      (dec_vd),
        .dec_illegal (dec_illegal),
        .dec_srca    (dec_srca),
        .dec_srcb    (dec_srcb)
    );

    vmul_execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_sew     (dec_sew),
        .dec_vd      (dec_vd),
        .dec_illegal (dec_illegal),
        .dec_srca    (dec_srca),
        .dec_srcb    (dec_srcb),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_sew      (ex_sew),
        .ex_vd       (ex_vd),
        .ex_illegal  (ex_illegal),
        .ex_prod_lo  (ex_prod_lo),
        .ex_prod_hi  (ex_prod_hi)
    );

    vmul_result u_result (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_sew      (ex_sew),
        .ex_vd       (ex_vd),
        .ex_illegal  (ex_illegal),
        .ex_prod_lo  (ex_prod_lo),
        .ex_prod_hi  (ex_prod_hi),
        .out_valid   (out_valid),
        .out_data_lo (out_data_lo),
        .out_data_hi (out_data_hi),
        .out_wide    (out_wide),
        .out_vd      (out_vd),
        .out_illegal (out_illegal)
    );

endmodule : vmul_unit

/* tb_vmul_unit.sv */
/*
 * Directed testbench for the vector multiply unit.
 * Drives products, latency, burst, back-pressure, illegal and reset tests
 * against a lane by lane reference model and an in-order scoreboard.
 */
module tb_vmul_unit;

    timeunit 1ns;
    timeprecision 1ps;

    import vmul_pkg::*;

    localparam int n_ops          = 170;
    localparam int latency        = 1 + mul_stages + 1;
    localparam int timeout_cycles = 2 * latency * n_ops + 200;  // Twice the latency per operation.

    typedef struct packed {
        vreg_data_t lo;
        vreg_data_t hi;
        logic       wide;
        logic       illegal;
        vreg_addr_t vd;
    } expect_t;

    logic       clk;
    logic       reset;
    logic       in_valid;
    instr_t     in_instr;
    vreg_data_t in_srca;
    vreg_data_t in_srcb;
    logic       in_ready;
    logic       out_valid;
    vreg_data_t out_data_lo;
    vreg_data_t out_data_hi;
    logic       out_wide;
    vreg_addr_t out_vd;
    logic       out_illegal;
    logic       out_ready;

    expect_t     exp_q[$];
    expect_t     held;
    logic        stalled = 1'b0;
    logic        bp_mode = 1'b0;
    logic        burst_check = 1'b0;
    int          burst_prev = -1;
    int          out_total = 0;
    int          cycles = 0;
    logic [31:0] lcg_state = 32'd42528;

    vmul_unit u_dut (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_srca     (in_srca),
        .in_srcb     (in_srcb),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_data_lo (out_data_lo),
        .out_data_hi (out_data_hi),
        .out_wide    (out_wide),
        .out_vd      (out_vd),
        .out_illegal (out_illegal),
        .out_ready   (out_ready)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "Run stopped.");
    endtask

    task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
        if (got !== exp) begin
            abort($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function vreg_data_t rand_vec();
        return {rand32(), rand32(), rand32(), rand32()};
    endfunction

    // A one in the least significant bit of every lane.
    function automatic vreg_data_t lane_ones(input logic [1:0] sew);
        vreg_data_t r;
        int w;
        r = '0;
        w = 8 << sew;
        for (int i = 0; i < vlen / w; i++) begin
            r = r | (128'd1 << (i * w));
        end
        return r;
    endfunction

    // Unsigned lanes, product i sits at bit 2*i*w of {hi, lo}.
    function automatic expect_t model(input logic [3:0] funct, input logic [1:0] sew,
                                      input logic [4:0] vd, input vreg_data_t a,
                                      input vreg_data_t b);
        expect_t     e;
        int          w;
        logic [127:0] mask;
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] p;
        logic [255:0] full;
        e = '0;
        e.vd = vd;
        w = 8 << sew;
        mask = (128'd1 << w) - 128'd1;
        full = '0;
        if (funct > 4'd2) begin
            e.illegal = 1'b1;
        end else begin
            for (int i = 0; i < vlen / w; i++) begin
                ea = (a >> (i * w)) & mask;
                eb = (b >> (i * w)) & mask;
                p = ea * eb;
                full = full | (256'(p) << (2 * i * w));
                if (funct == 4'd0) e.lo = e.lo | ((p & mask) << (i * w));
                if (funct == 4'd1) e.lo = e.lo | (((p >> w) & mask) << (i * w));
            end
            if (funct == 4'd2) begin
                e.lo   = full[127:0];
                e.hi   = full[255:128];
                e.wide = 1'b1;
            end
        end
        return e;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            abort($sformatf("Timeout after %0d cycles with %0d results outstanding.",
                            cycles, exp_q.size()));
        end
    end

    // Sampling at the falling edge sees the values of the next rising edge.
    always @(negedge clk) begin
        expect_t e;
        if (reset) begin
            stalled = 1'b0;
        end else begin
            check("in_ready", 256'(in_ready), 256'(!out_valid || out_ready));
            if (stalled) begin
                check("out_valid held", 256'(out_valid), 256'd1);
                check("out_data_lo held", 256'(out_data_lo), 256'(held.lo));
                check("out_data_hi held", 256'(out_data_hi), 256'(held.hi));
                check("out_wide held", 256'(out_wide), 256'(held.wide));
                check("out_illegal held", 256'(out_illegal), 256'(held.illegal));
                check("out_vd held", 256'(out_vd), 256'(held.vd));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    abort("An output was delivered with no instruction outstanding.");
                end else begin
                    e = exp_q.pop_front();
                    check("out_data_lo", 256'(out_data_lo), 256'(e.lo));
                    check("out_data_hi", 256'(out_data_hi), 256'(e.hi));
                    check("out_wide", 256'(out_wide), 256'(e.wide));
                    check("out_illegal", 256'(out_illegal), 256'(e.illegal));
                    check("out_vd", 256'(out_vd), 256'(e.vd));
                    out_total++;
                    if (burst_check && burst_prev >= 0) begin
                        check("output spacing", 256'(cycles - burst_prev), 256'd1);
                    end
                    burst_prev = cycles;
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(model(in_instr[3:0], in_instr[5:4], in_instr[10:6],
                                      in_srca, in_srcb));
            end
            stalled = out_valid && !out_ready;
            held = {out_data_lo, out_data_hi, out_wide, out_illegal, out_vd};
        end
    end

    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #2;
        if (bp_mode) begin
            r = rand32();
            out_ready = r[16];
        end
    endtask

    task automatic issue(input logic [3:0] funct, input logic [1:0] sew,
                         input vreg_data_t a, input vreg_data_t b);
        logic [31:0] r;
        logic        accepted;
        r = rand32();
        in_instr = {r[20:16], r[28:24], sew, funct};   // Junk in the ignored bits.
        in_srca  = a;
        in_srcb  = b;
        in_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            if (!bp_mode) check("in_ready", 256'(in_ready), 256'd1);
            next_cycle();
        end
    endtask

    task automatic wait_drain();
        in_valid = 1'b0;
        while (exp_q.size() != 0 || out_valid) begin
            next_cycle();
        end
    endtask

    task automatic test_products();
        for (int op = 0; op < 3; op++) begin
            for (int sew = 0; sew < 4; sew++) begin
                issue(4'(op), 2'(sew), '1, '1);
                issue(4'(op), 2'(sew), '1, '0);
                issue(4'(op), 2'(sew), lane_ones(2'(sew)), '1);
                issue(4'(op), 2'(sew), rand_vec(), rand_vec());
                issue(4'(op), 2'(sew), rand_vec(), rand_vec());
            end
        end
        wait_drain();
    endtask

    task automatic test_latency();
        int accept_cyc;
        in_instr = 16'h0022;    // Wide multiply, 32-bit lanes.
        in_srca  = rand_vec();
        in_srcb  = rand_vec();
        in_valid = 1'b1;
        @(negedge clk);
        check("in_ready", 256'(in_ready), 256'd1);
        accept_cyc = cycles;
        next_cycle();
        in_valid = 1'b0;
        do begin
            @(negedge clk);
        end while (!out_valid);
        check("latency", 256'(cycles - accept_cyc), 256'(latency));
        wait_drain();
    endtask

    task automatic test_back_to_back();
        int start_total;
        logic [31:0] r;
        start_total = out_total;
        burst_prev  = -1;
        burst_check = 1'b1;
        for (int n = 0; n < 40; n++) begin
            r = rand32();
            issue(4'(r[17:16] % 3), r[21:20], rand_vec(), rand_vec());
        end
        wait_drain();
        burst_check = 1'b0;
        check("burst output count", 256'(out_total - start_total), 256'd40);
    endtask

    task automatic test_back_pressure();
        int start_total;
        logic [31:0] r;
        start_total = out_total;
        bp_mode = 1'b1;
        for (int n = 0; n < 40; n++) begin
            r = rand32();
            issue(4'(r[17:16] % 3), r[21:20], rand_vec(), rand_vec());
        end
        wait_drain();
        bp_mode   = 1'b0;
        out_ready = 1'b1;
        check("stalled output count", 256'(out_total - start_total), 256'd40);
    endtask

    task automatic test_illegal();
        logic [31:0] r;
        for (int f = 3; f < 16; f++) begin
            r = rand32();
            issue(4'(f), r[21:20], rand_vec(), rand_vec());
        end
        wait_drain();
    endtask

    task automatic test_reset_midstream();
        logic [31:0] r;
        for (int n = 0; n < 8; n++) begin
            r = rand32();
            issue(4'(r[17:16] % 3), r[21:20], rand_vec(), rand_vec());
        end
        in_valid  = 1'b0;
        out_ready = 1'b0;   // The pipeline is held, so only reset can free the input.
        reset     = 1'b1;
        next_cycle();
        next_cycle();
        check("out_valid after reset", 256'(out_valid), 256'd0);
        check("in_ready after reset", 256'(in_ready), 256'd1);
        exp_q.delete();
        reset     = 1'b0;
        out_ready = 1'b1;
        for (int n = 0; n < 8; n++) begin
            r = rand32();
            issue(4'(r[17:16] % 3), r[21:20], rand_vec(), rand_vec());
        end
        wait_drain();
    endtask

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_srca   = '0;
        in_srcb   = '0;
        out_ready = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        test_products();
        test_latency();
        test_back_to_back();
        test_back_pressure();
        test_illegal();
        test_reset_midstream();
        $display("Everything OK");
        $finish;
    end

endmodule : tb_vmul_unit

/* vmul_unit.f */
vmul_pkg.sv
vmul_decode.sv
mul_array.sv
vmul_execute.sv
vmul_result.sv
vmul_unit.sv
tb_vmul_unit.sv

/* Makefile */
# Verilator build for the vector multiply unit testbench.
# Any variable can be overridden on the command line, e.g. make sim TOP=...

VERILATOR ?= verilator
TOP       ?= tb_vmul_unit
FILELIST  ?= vmul_unit.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
